/* all.f */
design/clock_pkg.sv
design/btn_if.sv
design/disp_if.sv
design/btn_cond.sv
design/mode_ctrl.sv
design/hms_cnt.sv
design/time_keeper.sv
design/alarm_unit.sv
design/disp_scan.sv
design/clock_top.sv
verification/clock_props.sv
verification/tb_clock_top.sv

/* design/alarm_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alarm_unit (
	input  logic                          clk,
	input  logic                          rst_n,
	btn_if.dst                            btn,
	input  logic [clock_pkg::MODE_W-1:0]  i_mode,
	input  logic [clock_pkg::POS_W-1:0]   i_pos,
	input  logic                          i_alarm_en,
	input  logic [clock_pkg::FIELD_W-1:0] i_sec,
	input  logic [clock_pkg::FIELD_W-1:0] i_min,
	input  logic [clock_pkg::FIELD_W-1:0] i_hr,
	disp_if.src                           disp,
	output logic                          o_alarm
);

	import clock_pkg::*;

	logic               edit;		// alarm-set mode with an inc press
	logic [FIELD_W-1:0] alm_sec;
	logic [FIELD_W-1:0] alm_min;
	logic [FIELD_W-1:0] alm_hr;
	logic               match;
	logic               alarm_q;

	assign edit = (i_mode == MODE_ALARM) && btn.inc_p;

	// ----------------------------------------
	// alarm time, set field by field
	// ----------------------------------------
	hms_cnt #(.MAX(SEC_MAX)) u_asec (
		.clk(clk), .rst_n(rst_n),
		.i_step(1'b0), .i_bump(edit && (i_pos == POS_SEC)),
		.o_value(alm_sec), .o_carry()
	);

	hms_cnt #(.MAX(SEC_MAX)) u_amin (
		.clk(clk), .rst_n(rst_n),
		.i_step(1'b0), .i_bump(edit && (i_pos == POS_MIN)),
		.o_value(alm_min), .o_carry()
	);

	hms_cnt #(.MAX(HR_MAX)) u_ahr (
		.clk(clk), .rst_n(rst_n),
		.i_step(1'b0), .i_bump(edit && (i_pos == POS_HR)),
		.o_value(alm_hr), .o_carry()
	);

	assign match = (i_sec == alm_sec) && (i_min == alm_min) && (i_hr == alm_hr);

	// set on a match, held until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_q <= 1'b0;
		end else if (!i_alarm_en) begin
			alarm_q <= 1'b0;
		end else if (match) begin
			alarm_q <= 1'b1;
		end
	end

	assign o_alarm = alarm_q;

	// alarm time only while it is being set
	always_comb begin
		if (i_mode == MODE_ALARM) begin
			disp.show_sec = alm_sec;
			disp.show_min = alm_min;
			disp.show_hr  = alm_hr;
		end else begin
			disp.show_sec = i_sec;
			disp.show_min = i_min;
			disp.show_hr  = i_hr;
		end
		disp.show_mode = i_mode;
	end

endmodule

`default_nettype wire

/* design/btn_cond.sv */
`timescale 1ns/1ps
`default_nettype none

module btn_cond (
	input  logic clk,
	input  logic rst_n,
	input  logic i_btn_mode,
	input  logic i_btn_pos,
	input  logic i_btn_inc,
	input  logic i_btn_alarm,
	btn_if.src   btn
);

	logic [3:0] raw;	// {alarm, inc, pos, mode}
	logic [3:0] sync1;
	logic [3:0] sync2;
	logic [3:0] hist;	// last synchronized level
	logic [3:0] pulse;

	assign raw = {i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode};

	// two-flop synchronizer plus history
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '0;
			sync2 <= '0;
			hist  <= '0;
		end else begin
			sync1 <= raw;
			sync2 <= sync1;
			hist  <= sync2;
		end
	end

	// rising edge of the clean level, registered
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pulse <= '0;
		end else begin
			pulse <= sync2 & ~hist;
		end
	end

	assign btn.mode_p  = pulse[0];
	assign btn.pos_p   = pulse[1];
	assign btn.inc_p   = pulse[2];
	assign btn.alarm_p = pulse[3];

endmodule

`default_nettype wire

/* design/btn_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one-cycle press events, one per button
interface btn_if;

	logic mode_p;	// next mode
	logic pos_p;	// next edit field
	logic inc_p;	// +1 on edit field
	logic alarm_p;	// toggle alarm enable

	modport src (
		output mode_p, pos_p, inc_p, alarm_p
	);

	modport dst (
		input mode_p, pos_p, inc_p, alarm_p
	);

endinterface

`default_nettype wire

/* design/clock_pkg.sv */
`default_nettype none

package clock_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int FIELD_W  = 6;	// one hh, mm or ss field
	localparam int DIGIT_W  = 4;	// bcd digit
	localparam int SEG_W    = 7;	// a..g
	localparam int N_DIGITS = 6;
	localparam int MODE_W   = 2;
	localparam int POS_W    = 2;

	// field limits
	localparam int SEC_MAX = 59;	// also minutes
	localparam int HR_MAX  = 23;

	// mode codes
	localparam logic [MODE_W-1:0] MODE_CLOCK = 2'd0;
	localparam logic [MODE_W-1:0] MODE_SETUP = 2'd1;
	localparam logic [MODE_W-1:0] MODE_ALARM = 2'd2;

	// edit position codes
	localparam logic [POS_W-1:0] POS_SEC = 2'd0;
	localparam logic [POS_W-1:0] POS_MIN = 2'd1;
	localparam logic [POS_W-1:0] POS_HR  = 2'd2;

	// dividers for a 50 MHz board clock
	localparam int DEF_SEC_DIV  = 50_000_000;
	localparam int DEF_SCAN_DIV = 5_000;

	// ----------------------------------------
	// seven-segment decode, a in the top bit
	// ----------------------------------------
	function automatic logic [SEG_W-1:0] seg_of_digit(input logic [DIGIT_W-1:0] digit);
		case (digit)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;	// not a digit, all dark
		endcase
	endfunction

endpackage

`default_nettype wire

/* design/clock_top.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_top #(
	parameter int SEC_DIV  = clock_pkg::DEF_SEC_DIV,
	parameter int SCAN_DIV = clock_pkg::DEF_SCAN_DIV
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           i_btn_mode,
	input  logic                           i_btn_pos,
	input  logic                           i_btn_inc,
	input  logic                           i_btn_alarm,
	output logic [clock_pkg::SEG_W-1:0]    o_seg,
	output logic [clock_pkg::N_DIGITS-1:0] o_seg_enb,
	output logic                           o_alarm
);

	import clock_pkg::*;

	btn_if  btn_bus ();
	disp_if disp_bus ();

	logic [MODE_W-1:0]  mode;
	logic [POS_W-1:0]   pos;
	logic               alarm_en;
	logic [FIELD_W-1:0] cur_sec;
	logic [FIELD_W-1:0] cur_min;
	logic [FIELD_W-1:0] cur_hr;

	// ----------------------------------------
	// input side
	// ----------------------------------------
	btn_cond u_btn_cond (
		.clk(clk), .rst_n(rst_n),
		.i_btn_mode(i_btn_mode), .i_btn_pos(i_btn_pos),
		.i_btn_inc(i_btn_inc), .i_btn_alarm(i_btn_alarm),
		.btn(btn_bus.src)
	);

	mode_ctrl u_mode_ctrl (
		.clk(clk), .rst_n(rst_n), .btn(btn_bus.dst),
		.o_mode(mode), .o_pos(pos), .o_alarm_en(alarm_en)
	);

	// ----------------------------------------
	// timekeeping and alarm
	// ----------------------------------------
	time_keeper #(.SEC_DIV(SEC_DIV)) u_time_keeper (
		.clk(clk), .rst_n(rst_n), .btn(btn_bus.dst),
		.i_mode(mode), .i_pos(pos),
		.o_sec(cur_sec), .o_min(cur_min), .o_hr(cur_hr)
	);

	alarm_unit u_alarm_unit (
		.clk(clk), .rst_n(rst_n), .btn(btn_bus.dst),
		.i_mode(mode), .i_pos(pos), .i_alarm_en(alarm_en),
		.i_sec(cur_sec), .i_min(cur_min), .i_hr(cur_hr),
		.disp(disp_bus.src), .o_alarm(o_alarm)
	);

	// display side
	disp_scan #(.SCAN_DIV(SCAN_DIV)) u_disp_scan (
		.clk(clk), .rst_n(rst_n), .disp(disp_bus.dst),
		.o_seg(o_seg), .o_seg_enb(o_seg_enb)
	);

endmodule

`default_nettype wire

/* design/disp_if.sv */
`timescale 1ns/1ps
`default_nettype none

// time and mode handed to the display side
interface disp_if;

	import clock_pkg::*;

	logic [FIELD_W-1:0] show_sec;
	logic [FIELD_W-1:0] show_min;
	logic [FIELD_W-1:0] show_hr;
	logic [MODE_W-1:0]  show_mode;

	modport src (
		output show_sec, show_min, show_hr, show_mode
	);

	modport dst (
		input show_sec, show_min, show_hr, show_mode
	);

endinterface

`default_nettype wire

/* design/disp_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module disp_scan #(
	parameter int SCAN_DIV = clock_pkg::DEF_SCAN_DIV
) (
	input  logic                           clk,
	input  logic                           rst_n,
	disp_if.dst                            disp,
	output logic [clock_pkg::SEG_W-1:0]    o_seg,
	output logic [clock_pkg::N_DIGITS-1:0] o_seg_enb
);

	import clock_pkg::*;

	localparam int               PRE_W    = $clog2(SCAN_DIV);
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(SCAN_DIV - 1);

	logic [PRE_W-1:0]   presc;
	logic               scan_step;
	logic [2:0]         digit_idx;	// 0..N_DIGITS-1, seconds ones first
	logic [FIELD_W-1:0] field;
	logic [DIGIT_W-1:0] digit;

	assign scan_step = (presc == PRE_LAST);

	// ----------------------------------------
	// scan timing
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			presc <= '0;
		end else begin
			presc <= scan_step ? '0 : presc + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			digit_idx <= '0;
		end else if (scan_step) begin
			digit_idx <= (digit_idx == 3'(N_DIGITS - 1)) ? '0 : digit_idx + 1'b1;
		end
	end

	// two digits per field
	always_comb begin
		case (digit_idx[2:1])
			2'd0:    field = disp.show_sec;
			2'd1:    field = disp.show_min;
			default: field = disp.show_hr;
		endcase
	end

	always_comb begin
		if (disp.show_mode > MODE_ALARM) begin
			digit = '1;				// undefined mode, blank
		end else if (digit_idx[0]) begin
			digit = DIGIT_W'(field / 10);	// tens
		end else begin
			digit = DIGIT_W'(field % 10);	// ones
		end
	end

	assign o_seg     = seg_of_digit(digit);
	assign o_seg_enb = ~(N_DIGITS'(1) << digit_idx);	// active low

endmodule

`default_nettype wire

/* design/hms_cnt.sv */
`timescale 1ns/1ps
`default_nettype none

module hms_cnt #(
	parameter int MAX = clock_pkg::SEC_MAX
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_step,	// counting, carry allowed
	input  logic                          i_bump,	// manual set, no carry
	output logic [clock_pkg::FIELD_W-1:0] o_value,
	output logic                          o_carry
);

	import clock_pkg::*;

	localparam logic [FIELD_W-1:0] LAST = FIELD_W'(MAX);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_value <= '0;
		end else if (i_step || i_bump) begin
			o_value <= (o_value >= LAST) ? '0 : o_value + 1'b1;
		end
	end

	assign o_carry = i_step && (o_value == LAST);

endmodule

`default_nettype wire

/* design/mode_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mode_ctrl (
	input  logic                         clk,
	input  logic                         rst_n,
	btn_if.dst                           btn,
	output logic [clock_pkg::MODE_W-1:0] o_mode,
	output logic [clock_pkg::POS_W-1:0]  o_pos,
	output logic                         o_alarm_en
);

	import clock_pkg::*;

	// clock -> setup -> alarm-set -> clock
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= MODE_CLOCK;
		end else if (btn.mode_p) begin
			case (o_mode)
				MODE_CLOCK: o_mode <= MODE_SETUP;
				MODE_SETUP: o_mode <= MODE_ALARM;
				default:    o_mode <= MODE_CLOCK;
			endcase
		end
	end

	// edited field, sec -> min -> hr
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_pos <= POS_SEC;
		end else if (btn.pos_p) begin
			case (o_pos)
				POS_SEC: o_pos <= POS_MIN;
				POS_MIN: o_pos <= POS_HR;
				default: o_pos <= POS_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_en <= 1'b0;
		end else if (btn.alarm_p) begin
			o_alarm_en <= ~o_alarm_en;
		end
	end

endmodule

`default_nettype wire

/* design/time_keeper.sv */
`timescale 1ns/1ps
`default_nettype none

module time_keeper #(
	parameter int SEC_DIV = clock_pkg::DEF_SEC_DIV
) (
	input  logic                          clk,
	input  logic                          rst_n,
	btn_if.dst                            btn,
	input  logic [clock_pkg::MODE_W-1:0]  i_mode,
	input  logic [clock_pkg::POS_W-1:0]   i_pos,
	output logic [clock_pkg::FIELD_W-1:0] o_sec,
	output logic [clock_pkg::FIELD_W-1:0] o_min,
	output logic [clock_pkg::FIELD_W-1:0] o_hr
);

	import clock_pkg::*;

	localparam int                 PRE_W    = $clog2(SEC_DIV);
	localparam logic [PRE_W-1:0]   PRE_LAST = PRE_W'(SEC_DIV - 1);

	logic [PRE_W-1:0] presc;
	logic             setup;
	logic             tick;		// one cycle per second
	logic             sec_carry;
	logic             min_carry;

	assign setup = (i_mode == MODE_SETUP);
	assign tick  = !setup && (presc == PRE_LAST);

	// ----------------------------------------
	// seconds prescaler, parked in setup
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			presc <= '0;
		end else if (setup || tick) begin
			presc <= '0;
		end else begin
			presc <= presc + 1'b1;
		end
	end

	hms_cnt #(.MAX(SEC_MAX)) u_sec (
		.clk(clk), .rst_n(rst_n),
		.i_step(tick),
		.i_bump(setup && btn.inc_p && (i_pos == POS_SEC)),
		.o_value(o_sec), .o_carry(sec_carry)
	);

	hms_cnt #(.MAX(SEC_MAX)) u_min (
		.clk(clk), .rst_n(rst_n),
		.i_step(sec_carry),
		.i_bump(setup && btn.inc_p && (i_pos == POS_MIN)),
		.o_value(o_min), .o_carry(min_carry)
	);

	hms_cnt #(.MAX(HR_MAX)) u_hr (
		.clk(clk), .rst_n(rst_n),
		.i_step(min_carry),
		.i_bump(setup && btn.inc_p && (i_pos == POS_HR)),
		.o_value(o_hr), .o_carry()	// day rollover not needed
	);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert \
	-f all.f --top-module tb_clock_top \
	-Mdir obj_dir -o tb_clock_top \
	&& ./obj_dir/tb_clock_top > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0

/* verification/clock_props.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_props (
	input logic                           clk,
	input logic                           rst_n,
	input logic [clock_pkg::N_DIGITS-1:0] i_seg_enb,
	input logic                           i_alarm,
	input logic                           i_alarm_en,
	input logic                           i_mode_p,
	input logic                           i_pos_p,
	input logic                           i_inc_p,
	input logic                           i_alarm_p
);

	// ----------------------------------------
	// display scan
	// ----------------------------------------
	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(~i_seg_enb) == 1)
		else $error("o_seg_enb does not have exactly one low bit");

	// alarm only latches while enabled
	a_alarm_gated: assert property (@(posedge clk) disable iff (!rst_n)
		!i_alarm_en |=> !$rose(i_alarm))
		else $error("o_alarm rose while the alarm was disabled");

	// ----------------------------------------
	// press events, one cycle each
	// ----------------------------------------
	a_mode_pulse: assert property (@(posedge clk) disable iff (!rst_n) i_mode_p |=> !i_mode_p)
		else $error("mode pulse longer than one cycle");
	a_pos_pulse: assert property (@(posedge clk) disable iff (!rst_n) i_pos_p |=> !i_pos_p)
		else $error("position pulse longer than one cycle");
	a_inc_pulse: assert property (@(posedge clk) disable iff (!rst_n) i_inc_p |=> !i_inc_p)
		else $error("increment pulse longer than one cycle");
	a_alarm_pulse: assert property (@(posedge clk) disable iff (!rst_n) i_alarm_p |=> !i_alarm_p)
		else $error("alarm toggle pulse longer than one cycle");

endmodule

bind clock_top clock_props props_i (
	.clk(clk), .rst_n(rst_n),
	.i_seg_enb(o_seg_enb), .i_alarm(o_alarm), .i_alarm_en(alarm_en),
	.i_mode_p(btn_bus.mode_p), .i_pos_p(btn_bus.pos_p),
	.i_inc_p(btn_bus.inc_p), .i_alarm_p(btn_bus.alarm_p)
);

`default_nettype wire

/* verification/tb_clock_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_top;

	import clock_pkg::*;

	localparam int SEC_DIV    = 40;
	localparam int SCAN_DIV   = 2;
	localparam int READ_LIMIT = 4 * N_DIGITS * SCAN_DIV + 4;	// cycles for one display read
	localparam int POLL_READS = SEC_DIV / (N_DIGITS * SCAN_DIV) + 1;
	localparam int MAX_ROWS   = 40;
	localparam logic [31:0] SEED = 32'h48ee935e;

	// row actions
	localparam int ACT_PRESS = 0;
	localparam int ACT_INC   = 1;	// arg = number of inc presses
	localparam int ACT_WAIT  = 2;	// arg = seconds
	localparam int ACT_ALARM = 3;	// wait for o_alarm, arg = seconds max

	localparam int B_MODE  = 0;
	localparam int B_POS   = 1;
	localparam int B_INC   = 2;
	localparam int B_ALARM = 3;

	logic                clk;
	logic                rst_n;
	logic                i_btn_mode;
	logic                i_btn_pos;
	logic                i_btn_inc;
	logic                i_btn_alarm;
	logic [SEG_W-1:0]    o_seg;
	logic [N_DIGITS-1:0] o_seg_enb;
	logic                o_alarm;

	int          mismatches;
	int          failures;	// timeouts and stalls
	logic [31:0] rng;

	// ----------------------------------------
	// stimulus table
	// ----------------------------------------
	int n_rows;
	int row_act   [MAX_ROWS];
	int row_arg   [MAX_ROWS];
	bit row_chk   [MAX_ROWS];	// compare the shown time
	int row_hr    [MAX_ROWS];
	int row_min   [MAX_ROWS];
	int row_sec   [MAX_ROWS];
	bit row_alarm [MAX_ROWS];

	clock_top #(.SEC_DIV(SEC_DIV), .SCAN_DIV(SCAN_DIV)) dut_i (
		.clk(clk), .rst_n(rst_n),
		.i_btn_mode(i_btn_mode), .i_btn_pos(i_btn_pos),
		.i_btn_inc(i_btn_inc), .i_btn_alarm(i_btn_alarm),
		.o_seg(o_seg), .o_seg_enb(o_seg_enb), .o_alarm(o_alarm)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// inverse of the segment table, 15 for anything else
	function automatic int digit_of_seg(input logic [SEG_W-1:0] seg);
		case (seg)
			7'b111_1110: return 0;
			7'b011_0000: return 1;
			7'b110_1101: return 2;
			7'b111_1001: return 3;
			7'b011_0011: return 4;
			7'b101_1011: return 5;
			7'b101_1111: return 6;
			7'b111_0000: return 7;
			7'b111_1111: return 8;
			7'b111_0011: return 9;
			default:     return 15;
		endcase
	endfunction

	function automatic int count_low(input logic [N_DIGITS-1:0] enb);
		int n;
		n = 0;
		for (int i = 0; i < N_DIGITS; i++) begin
			if (!enb[i])
				n++;
		end
		return n;
	endfunction

	function automatic int low_index(input logic [N_DIGITS-1:0] enb);
		for (int i = 0; i < N_DIGITS; i++) begin
			if (!enb[i])
				return i;
		end
		return -1;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic set_button(input int which, input logic level);
		case (which)
			B_MODE:  i_btn_mode  = level;
			B_POS:   i_btn_pos   = level;
			B_INC:   i_btn_inc   = level;
			default: i_btn_alarm = level;
		endcase
	endtask

	// 3 cycles held, 3 released
	task automatic press_button(input int which);
		@(posedge clk);
		#1 set_button(which, 1'b1);
		repeat (3) @(posedge clk);
		#1 set_button(which, 1'b0);
		repeat (3) @(posedge clk);
	endtask

	// ----------------------------------------
	// display reader
	// ----------------------------------------
	task automatic read_display(output bit ok, output int hr, output int mn, output int sc);
		int                  digits [N_DIGITS];
		logic [N_DIGITS-1:0] seen;
		int                  idx;
		int                  cycles;
		seen   = '0;
		cycles = 0;
		foreach (digits[i])
			digits[i] = 0;
		while (seen != '1 && cycles < READ_LIMIT) begin
			@(negedge clk);
			cycles++;
			if (count_low(o_seg_enb) == 1) begin
				idx         = low_index(o_seg_enb);
				digits[idx] = digit_of_seg(o_seg);
				seen[idx]   = 1'b1;
			end
		end
		ok = (seen == '1);
		sc = digits[1] * 10 + digits[0];
		mn = digits[3] * 10 + digits[2];
		hr = digits[5] * 10 + digits[4];
	endtask

	// read until the time shows up or about one second passes
	task automatic expect_time(input int hr, input int mn, input int sc);
		bit ok;
		int got_hr;
		int got_min;
		int got_sec;
		int tries;
		tries = 0;
		read_display(ok, got_hr, got_min, got_sec);
		while (ok && !(got_hr == hr && got_min == mn && got_sec == sc) && tries < POLL_READS) begin
			tries++;
			read_display(ok, got_hr, got_min, got_sec);
		end
		if (!ok) begin
			failures++;
			$display("display scan stalled, not all six digits were seen");
		end else begin
			check_val("hours", 32'(got_hr), 32'(hr));
			check_val("minutes", 32'(got_min), 32'(mn));
			check_val("seconds", 32'(got_sec), 32'(sc));
		end
	endtask

	task automatic wait_alarm(input int secs);
		int cycles;
		cycles = 0;
		while (o_alarm !== 1'b1 && cycles < secs * SEC_DIV) begin
			@(negedge clk);
			cycles++;
		end
		if (o_alarm !== 1'b1) begin
			failures++;
			$display("o_alarm did not rise within %0d seconds", secs);
		end
	endtask

	// 12 scan steps, one low bit each, digits in order
	task automatic check_scan();
		logic [N_DIGITS-1:0] last;
		int                  exp_idx;
		int                  cycles;
		@(negedge clk);
		last    = o_seg_enb;
		exp_idx = low_index(o_seg_enb);
		for (int step = 0; step < 12; step++) begin
			cycles = 0;
			while (o_seg_enb == last && cycles < 4 * SCAN_DIV) begin
				@(negedge clk);
				cycles++;
			end
			if (o_seg_enb == last) begin
				failures++;
				$display("digit scan did not advance within %0d cycles", 4 * SCAN_DIV);
			end
			exp_idx = (exp_idx + 1) % N_DIGITS;
			check_val("o_seg_enb low bits", 32'(count_low(o_seg_enb)), 32'd1);
			check_val("digit index", 32'(low_index(o_seg_enb)), 32'(exp_idx));
			last = o_seg_enb;
		end
	endtask

	task automatic add_row(input int act, input int arg, input bit chk,
		input int hr, input int mn, input int sc, input bit alarm);
		row_act[n_rows]   = act;
		row_arg[n_rows]   = arg;
		row_chk[n_rows]   = chk;
		row_hr[n_rows]    = hr;
		row_min[n_rows]   = mn;
		row_sec[n_rows]   = sc;
		row_alarm[n_rows] = alarm;
		n_rows++;
	endtask

	task automatic build_table();
		int n_sec;
		int n_min;
		int n_hr;
		int s;
		int m;
		int h;
		rng   = xorshift32(rng);
		n_sec = 61 + int'(rng % 32'd70);
		rng   = xorshift32(rng);
		n_min = 61 + int'(rng % 32'd70);
		rng   = xorshift32(rng);
		n_hr  = 25 + int'(rng % 32'd40);
		s = n_sec % 60;
		m = n_min % 60;
		h = n_hr % 24;
		n_rows = 0;
		// carry through the hour
		add_row(ACT_PRESS, B_MODE, 1, 0, 0, 0, 0);	// setup
		add_row(ACT_INC, 55, 1, 0, 0, 55, 0);
		add_row(ACT_PRESS, B_POS, 0, 0, 0, 0, 0);
		add_row(ACT_INC, 59, 1, 0, 59, 55, 0);
		add_row(ACT_PRESS, B_MODE, 1, 0, 0, 0, 0);	// alarm-set shows alarm time
		add_row(ACT_PRESS, B_MODE, 0, 0, 0, 0, 0);
		add_row(ACT_WAIT, 10, 1, 1, 0, 5, 0);
		// day rollover
		add_row(ACT_PRESS, B_MODE, 1, 1, 0, 5, 0);
		add_row(ACT_INC, 59, 1, 1, 59, 5, 0);
		add_row(ACT_PRESS, B_POS, 0, 0, 0, 0, 0);
		add_row(ACT_INC, 22, 1, 23, 59, 5, 0);
		add_row(ACT_PRESS, B_POS, 0, 0, 0, 0, 0);
		add_row(ACT_INC, 53, 1, 23, 59, 58, 0);
		add_row(ACT_PRESS, B_MODE, 1, 0, 0, 0, 0);
		add_row(ACT_PRESS, B_MODE, 0, 0, 0, 0, 0);
		add_row(ACT_WAIT, 2, 1, 0, 0, 0, 0);
		// setup wraps, clock stopped
		add_row(ACT_PRESS, B_MODE, 1, 0, 0, 0, 0);
		add_row(ACT_INC, n_sec, 1, 0, 0, s, 0);
		add_row(ACT_WAIT, 3, 1, 0, 0, s, 0);
		add_row(ACT_PRESS, B_POS, 0, 0, 0, 0, 0);
		add_row(ACT_INC, n_min, 1, 0, m, s, 0);
		add_row(ACT_PRESS, B_POS, 0, 0, 0, 0, 0);
		add_row(ACT_INC, n_hr, 1, h, m, s, 0);
		// clock to 00:00:57, alarm to 00:01:00
		add_row(ACT_INC, (24 - h) % 24, 1, 0, m, s, 0);
		add_row(ACT_PRESS, B_POS, 0, 0, 0, 0, 0);
		add_row(ACT_INC, (57 - s + 60) % 60, 1, 0, m, 57, 0);
		add_row(ACT_PRESS, B_POS, 0, 0, 0, 0, 0);
		add_row(ACT_INC, (60 - m) % 60, 1, 0, 0, 57, 0);
		add_row(ACT_PRESS, B_ALARM, 1, 0, 0, 57, 0);
		add_row(ACT_PRESS, B_MODE, 1, 0, 0, 0, 0);
		add_row(ACT_INC, 1, 1, 0, 1, 0, 0);
		add_row(ACT_PRESS, B_MODE, 0, 0, 0, 0, 0);
		add_row(ACT_ALARM, 5, 0, 0, 0, 0, 1);
		add_row(ACT_WAIT, 3, 0, 0, 0, 0, 1);	// past the match, still latched
		add_row(ACT_PRESS, B_ALARM, 0, 0, 0, 0, 0);
	endtask

	task automatic run_row(input int r);
		case (row_act[r])
			ACT_PRESS: press_button(row_arg[r]);
			ACT_INC:   repeat (row_arg[r]) press_button(B_INC);
			ACT_WAIT:  repeat ((row_arg[r] - 1) * SEC_DIV) @(posedge clk);	// poll takes the last one
			default:   wait_alarm(row_arg[r]);
		endcase
		if (row_chk[r])
			expect_time(row_hr[r], row_min[r], row_sec[r]);
		@(negedge clk);
		check_val("o_alarm", 32'(o_alarm), 32'(row_alarm[r]));
	endtask

	initial begin
		rst_n       = 1'b0;
		i_btn_mode  = 1'b0;
		i_btn_pos   = 1'b0;
		i_btn_inc   = 1'b0;
		i_btn_alarm = 1'b0;
		mismatches  = 0;
		failures    = 0;
		rng         = SEED;
		build_table();
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		@(negedge clk);
		check_val("o_seg_enb", 32'(o_seg_enb), 32'h3e);
		check_val("o_alarm", 32'(o_alarm), 32'd0);
		expect_time(0, 0, 0);	// before the first tick
		for (int r = 0; r < n_rows; r++)
			run_row(r);
		check_scan();
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
